// ==== soc_bus_params.svh ====
// Slot count, Wishbone widths and memory depth macros for the SoC bus
`ifndef SOC_BUS_PARAMS_SVH
`define SOC_BUS_PARAMS_SVH

// Wishbone slots
// --------------------

// Number of peripheral slots, one cyc/ack pair each
`define SOC_WB_N 2

// Word address width seen by a slot
`define SOC_WB_AW 16

// Slot data width
`define SOC_WB_DW 32

// Memories
// --------------------

// BRAM, 256 words at 0x00000000
`define SOC_BRAM_AW 8

// SPRAM, 32768 words at 0x00020000
`define SOC_SPRAM_AW 15

`endif

// ==== soc_bus_pkg.sv ====
// Bus vector typedefs, request/response structs and slot FSM states
`include "soc_bus_params.svh"

package soc_bus_pkg;

	// Plain vectors
	// --------------------
	typedef logic [31:0] cpu_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0] byte_strb_t;
	typedef logic [`SOC_SPRAM_AW-1:0] ram_addr_t;
	typedef logic [`SOC_WB_AW-1:0] wb_addr_t;
	typedef logic [`SOC_WB_N-1:0] wb_sel_t;

	// Bundles
	// --------------------

	// CPU side request, held until ready
	typedef struct packed {
		cpu_addr_t addr;
		bus_data_t wdata;
		byte_strb_t wstrb;
		logic valid;
	} cpu_req_t;

	typedef struct packed {
		bus_data_t rdata;
		logic ready;
	} cpu_rsp_t;

	// Shared by both RAMs, set mask bit keeps the byte
	typedef struct packed {
		ram_addr_t addr;
		bus_data_t wdata;
		byte_strb_t wmsk;
		logic we;
	} ram_req_t;

	// Broadcast to every slot, cyc is per slot
	typedef struct packed {
		wb_addr_t addr;
		bus_data_t wdata;
		byte_strb_t wmsk;
		logic we;
	} wb_req_t;

	// Slot ack sequencer
	typedef enum logic [1:0] {
		WB_IDLE,
		WB_WAIT,
		WB_ACK
	} wb_state_t;

endpackage

// ==== soc_bus_top.sv ====
// SoC bus top: bridge, BRAM and SPRAM instances, two Wishbone scratch slots
`include "soc_bus_params.svh"

module soc_bus_top (
	input  logic                  clk,
	input  logic                  wb_cyc_rst,
	input  soc_bus_pkg::cpu_req_t cpu_req,
	output soc_bus_pkg::cpu_rsp_t cpu_rsp
);

	soc_bus_pkg::ram_req_t ram_req;
	logic bram_we;
	logic spram_we;
	soc_bus_pkg::bus_data_t bram_rdata;
	soc_bus_pkg::bus_data_t spram_rdata;

	soc_bus_pkg::wb_req_t wb_req;
	soc_bus_pkg::wb_sel_t wb_cyc;
	soc_bus_pkg::wb_sel_t wb_ack;
	soc_bus_pkg::bus_data_t wb_rdata [`SOC_WB_N];

	soc_cpu_bridge u_bridge (
		.clk         (clk),
		.wb_cyc_rst  (wb_cyc_rst),
		.cpu_req     (cpu_req),
		.cpu_rsp     (cpu_rsp),
		.ram_req     (ram_req),
		.bram_we     (bram_we),
		.spram_we    (spram_we),
		.bram_rdata  (bram_rdata),
		.spram_rdata (spram_rdata),
		.wb_req      (wb_req),
		.wb_cyc      (wb_cyc),
		.wb_ack      (wb_ack),
		.wb_rdata    (wb_rdata)
	);

	// Memories
	// --------------------
	soc_word_ram #(.DEPTH_AW(`SOC_BRAM_AW)) u_bram (
		.clk   (clk),
		.req   (ram_req),
		.we    (bram_we),
		.rdata (bram_rdata)
	);

	soc_word_ram #(.DEPTH_AW(`SOC_SPRAM_AW)) u_spram (
		.clk   (clk),
		.req   (ram_req),
		.we    (spram_we),
		.rdata (spram_rdata)
	);

	// Peripheral slots
	// --------------------
	soc_wb_regs #(.ACK_WAIT(0)) u_slot0 (
		.clk        (clk),
		.wb_cyc_rst (wb_cyc_rst),
		.req        (wb_req),
		.cyc        (wb_cyc[0]),
		.ack        (wb_ack[0]),
		.rdata      (wb_rdata[0])
	);

	// Slower slot, two wait states before ack
	soc_wb_regs #(.ACK_WAIT(2)) u_slot1 (
		.clk        (clk),
		.wb_cyc_rst (wb_cyc_rst),
		.req        (wb_req),
		.cyc        (wb_cyc[1]),
		.ack        (wb_ack[1]),
		.rdata      (wb_rdata[1])
	);

endmodule

// ==== soc_cpu_bridge.sv ====
// CPU bus bridge: RAM and Wishbone slot decode, ready and read data merge
`include "soc_bus_params.svh"

module soc_cpu_bridge (
	input  logic                   clk,
	input  logic                   wb_cyc_rst,

	// CPU bus
	input  soc_bus_pkg::cpu_req_t  cpu_req,
	output soc_bus_pkg::cpu_rsp_t  cpu_rsp,

	// RAMs
	output soc_bus_pkg::ram_req_t  ram_req,
	output logic                   bram_we,
	output logic                   spram_we,
	input  soc_bus_pkg::bus_data_t bram_rdata,
	input  soc_bus_pkg::bus_data_t spram_rdata,

	// Wishbone slots
	output soc_bus_pkg::wb_req_t   wb_req,
	output soc_bus_pkg::wb_sel_t   wb_cyc,
	input  soc_bus_pkg::wb_sel_t   wb_ack,
	input  soc_bus_pkg::bus_data_t wb_rdata [`SOC_WB_N]
);

	logic ram_sel;
	logic ram_rdy;
	soc_bus_pkg::bus_data_t ram_rdata;

	soc_bus_pkg::wb_sel_t wb_match;
	logic wb_cyc_kill;
	logic wb_rdy;
	soc_bus_pkg::bus_data_t wb_rdata_or;
	soc_bus_pkg::bus_data_t wb_rdata_reg;

	// RAM access
	// --------------------
	// BRAM at 0x00000000, SPRAM at 0x00020000, bit 17 picks one

	assign ram_sel = cpu_req.valid & ~cpu_req.addr[31];

	assign ram_req.addr  = cpu_req.addr[`SOC_SPRAM_AW+1:2];
	assign ram_req.wdata = cpu_req.wdata;
	assign ram_req.wmsk  = ~cpu_req.wstrb;
	assign ram_req.we    = ram_sel & |cpu_req.wstrb;

	assign bram_we  = ram_req.we & ~cpu_req.addr[17];
	assign spram_we = ram_req.we &  cpu_req.addr[17];

	always_comb begin
		if (cpu_req.addr[31])
			ram_rdata = '0;
		else if (cpu_req.addr[17])
			ram_rdata = spram_rdata;
		else
			ram_rdata = bram_rdata;
	end

	// One wait state, the pulse clears itself
	always_ff @(posedge clk) begin
		if (wb_cyc_rst)
			ram_rdy <= 1'b0;
		else
			ram_rdy <= ram_sel & ~ram_rdy;
	end

	// Wishbone
	// --------------------
	// Slot s at 0x8s000000

	always_comb begin
		wb_match = '0;
		for (int i = 0; i < `SOC_WB_N; i++)
			wb_match[i] = (cpu_req.addr[27:24] == 4'(i));
	end

	// Drop cyc as soon as the registered ack shows, no second access
	assign wb_cyc_kill = ~cpu_req.valid | ~cpu_req.addr[31] | wb_rdy;
	assign wb_cyc = wb_cyc_kill ? '0 : wb_match;

	assign wb_req.addr  = cpu_req.addr[`SOC_WB_AW+1:2];
	assign wb_req.wdata = cpu_req.wdata;
	assign wb_req.wmsk  = ~cpu_req.wstrb;
	assign wb_req.we    = |cpu_req.wstrb;

	// Idle slots return zero
	always_comb begin
		wb_rdata_or = '0;
		for (int i = 0; i < `SOC_WB_N; i++)
			wb_rdata_or = wb_rdata_or | wb_rdata[i];
	end

	always_ff @(posedge clk) begin
		if (wb_cyc_rst) begin
			wb_rdy       <= 1'b0;
			wb_rdata_reg <= '0;
		end else begin
			wb_rdy       <= |wb_ack;
			wb_rdata_reg <= wb_rdata_or;
		end
	end

	// Response merge
	// --------------------
	assign cpu_rsp.rdata = ram_rdata | wb_rdata_reg;
	assign cpu_rsp.ready = ram_rdy | wb_rdy;

	// Only one slot may acknowledge at a time
	a_ack_onehot: assert property (@(posedge clk) disable iff (wb_cyc_rst)
		$onehot0(wb_ack));

	// Ready answers a pending request, from RAM or a slot ack
	a_ready_valid: assert property (@(posedge clk) disable iff (wb_cyc_rst)
		$rose(cpu_rsp.ready) |-> cpu_req.valid);

endmodule

// ==== soc_wb_regs.sv ====
// Wishbone slot with four byte-writable scratch registers and ack wait states
`include "soc_bus_params.svh"

module soc_wb_regs #(
	parameter int ACK_WAIT = 0
) (
	input  logic                   clk,
	input  logic                   wb_cyc_rst,
	input  soc_bus_pkg::wb_req_t   req,
	input  logic                   cyc,
	output logic                   ack,
	output soc_bus_pkg::bus_data_t rdata
);

	localparam int CW = (ACK_WAIT > 1) ? $clog2(ACK_WAIT) : 1;

	soc_bus_pkg::wb_state_t state;
	logic [CW-1:0] wait_cnt;
	soc_bus_pkg::bus_data_t regs [4];
	logic [1:0] sel;

	assign sel = req.addr[1:0];

	// Ack sequencer
	// --------------------
	always_ff @(posedge clk) begin
		if (wb_cyc_rst) begin
			state    <= soc_bus_pkg::WB_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				soc_bus_pkg::WB_IDLE: begin
					wait_cnt <= '0;
					if (cyc) begin
						if (ACK_WAIT == 0)
							state <= soc_bus_pkg::WB_ACK;
						else
							state <= soc_bus_pkg::WB_WAIT;
					end
				end
				soc_bus_pkg::WB_WAIT: begin
					// Master gave up, abandon the access
					if (!cyc)
						state <= soc_bus_pkg::WB_IDLE;
					else if (wait_cnt == CW'(ACK_WAIT - 1))
						state <= soc_bus_pkg::WB_ACK;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				// Single cycle ack, always back to idle
				default: state <= soc_bus_pkg::WB_IDLE;
			endcase
		end
	end

	assign ack = (state == soc_bus_pkg::WB_ACK);

	// Registers
	// --------------------
	always_ff @(posedge clk) begin
		if (wb_cyc_rst) begin
			regs <= '{default: '0};
		end else if (ack && cyc && req.we) begin
			for (int b = 0; b < `SOC_WB_DW / 8; b++) begin
				if (!req.wmsk[b])
					regs[sel][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
	end

	// Zero outside ack so the bridge can OR all slots
	assign rdata = ack ? regs[sel] : '0;

	// Bridge must keep cyc up through the ack cycle
	a_ack_cyc: assert property (@(posedge clk) disable iff (wb_cyc_rst)
		ack |-> cyc);

endmodule

// ==== soc_word_ram.sv ====
// Word RAM with byte write mask and registered read
`include "soc_bus_params.svh"

module soc_word_ram #(
	parameter int DEPTH_AW = `SOC_BRAM_AW
) (
	input  logic                   clk,
	input  soc_bus_pkg::ram_req_t  req,
	input  logic                   we,
	output soc_bus_pkg::bus_data_t rdata
);

	localparam int NB = $bits(soc_bus_pkg::byte_strb_t);

	soc_bus_pkg::bus_data_t mem [0:(1 << DEPTH_AW) - 1];
	logic [DEPTH_AW-1:0] idx;

	// Upper address bits ignored, BRAM just wraps
	assign idx = req.addr[DEPTH_AW-1:0];

	// Write port
	// --------------------
	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < NB; b++) begin
				if (!req.wmsk[b])
					mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
	end

	// Read port
	// --------------------
	// Old data on a same-cycle write
	always_ff @(posedge clk) begin
		rdata <= mem[idx];
	end

endmodule

// ==== tb_soc_bus.sv ====
// Testbench for the SoC bus: clock, reset, LFSR stimulus, reference model, checker, timeout
`include "soc_bus_params.svh"

module tb_soc_bus;

	localparam int T_BRAM  = 0;
	localparam int T_SPRAM = 1;
	localparam int T_SLOT0 = 2;
	localparam int T_SLOT1 = 3;

	localparam int N_RESET = 10;
	localparam int N_FULL  = 16;
	localparam int N_STRB  = 8;
	localparam int N_ALIAS = 8;
	localparam int N_RAND  = 400;
	localparam int N_OPS   = 8 + N_FULL * 4 + N_STRB * 8 + N_ALIAS * 4 + N_RAND;
	localparam int LIMIT   = N_OPS * 6 + N_RESET + 100;

	logic clk = 1'b0;
	logic wb_cyc_rst;
	soc_bus_pkg::cpu_req_t cpu_req;
	soc_bus_pkg::cpu_rsp_t cpu_rsp;

	logic [31:0] lfsr_state = 32'h40c60db7;
	int cycle_cnt = 0;

	// Reference model, slot key is slot * 4 + register
	soc_bus_pkg::bus_data_t bram_mdl [int];
	soc_bus_pkg::bus_data_t spram_mdl [int];
	soc_bus_pkg::bus_data_t slot_mdl [int];
	int bram_q [$];
	int spram_q [$];

	// Read results waiting for the checker
	soc_bus_pkg::bus_data_t exp_q [$];
	soc_bus_pkg::bus_data_t act_q [$];
	soc_bus_pkg::cpu_addr_t addr_q [$];

	soc_bus_top dut (
		.clk        (clk),
		.wb_cyc_rst (wb_cyc_rst),
		.cpu_req    (cpu_req),
		.cpu_rsp    (cpu_rsp)
	);

	always #4 clk = ~clk;

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > LIMIT)
			stop_failed($sformatf("Timeout: run did not finish within %0d clock cycles", LIMIT));
	end

	// Random bits
	// --------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Spread over the top and bottom of SPRAM so low bits meet BRAM words
	function automatic int spram_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = rand_bits(2);
		lo = rand_bits(`SOC_BRAM_AW);
		return int'((hi << 13) | lo);
	endfunction

	// Reference model
	// --------------------
	function automatic soc_bus_pkg::cpu_addr_t make_addr(input int target, input int word);
		case (target)
			T_BRAM:  return {22'b0, word[7:0], 2'b00};
			T_SPRAM: return 32'h0002_0000 | {15'b0, word[14:0], 2'b00};
			default: return 32'h8000_0000 | (32'(target - T_SLOT0) << 24) | {28'b0, word[1:0], 2'b00};
		endcase
	endfunction

	// Cycle count up to the edge where the master takes ready
	function automatic int latency_of(input int target);
		case (target)
			T_BRAM, T_SPRAM: return 2;
			T_SLOT0:         return 3;
			default:         return 5;
		endcase
	endfunction

	function automatic logic known_word(input int target, input int word);
		if (target == T_BRAM)
			return bram_mdl.exists(word);
		else
			return spram_mdl.exists(word);
	endfunction

	// Applies the strobes and returns the word as it stands afterwards
	function automatic soc_bus_pkg::bus_data_t model_access(input int target, input int word,
			input soc_bus_pkg::bus_data_t wdata, input soc_bus_pkg::byte_strb_t wstrb);
		soc_bus_pkg::bus_data_t cur;
		int key;
		int b;
		key = (target >= T_SLOT0) ? (target - T_SLOT0) * 4 + word : word;
		cur = '0;
		if (target == T_BRAM && bram_mdl.exists(key))
			cur = bram_mdl[key];
		else if (target == T_SPRAM && spram_mdl.exists(key))
			cur = spram_mdl[key];
		else if (target >= T_SLOT0 && slot_mdl.exists(key))
			cur = slot_mdl[key];
		for (b = 0; b < 4; b++) begin
			if (wstrb[b])
				cur[8*b +: 8] = wdata[8*b +: 8];
		end
		if (wstrb != '0) begin
			if (target == T_BRAM)
				bram_mdl[key] = cur;
			else if (target == T_SPRAM)
				spram_mdl[key] = cur;
			else
				slot_mdl[key] = cur;
		end
		return cur;
	endfunction

	// Bus access
	// --------------------
	// Called and returns on a falling edge
	task automatic run_op(input int target, input int word, input soc_bus_pkg::bus_data_t wdata,
			input soc_bus_pkg::byte_strb_t wstrb);
		soc_bus_pkg::bus_data_t exp_word;
		int cycles;
		logic seen;
		if (wstrb != '0 && target == T_BRAM && !known_word(target, word))
			bram_q.push_back(word);
		if (wstrb != '0 && target == T_SPRAM && !known_word(target, word))
			spram_q.push_back(word);
		exp_word = model_access(target, word, wdata, wstrb);
		cpu_req.addr  = make_addr(target, word);
		cpu_req.wdata = wdata;
		cpu_req.wstrb = wstrb;
		cpu_req.valid = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			cycles++;
			seen = (cpu_rsp.ready === 1'b1);
		end
		if (wstrb == '0) begin
			exp_q.push_back(exp_word);
			act_q.push_back(cpu_rsp.rdata);
			addr_q.push_back(cpu_req.addr);
		end
		assert (cycles + 1 == latency_of(target)) else
			stop_failed($sformatf("ERROR %0t: addr %08h took %0d cycles, expected %0d",
				$time, cpu_req.addr, cycles + 1, latency_of(target)));
		// Request stays up through the edge that takes ready
		@(negedge clk);
		assert (cpu_rsp.ready === 1'b0) else
			stop_failed($sformatf("ERROR %0t: addr %08h ready longer than one cycle",
				$time, cpu_req.addr));
		cpu_req.valid = 1'b0;
	endtask

	// Mix of reads and writes over all four targets
	task automatic random_op();
		int target;
		int word;
		soc_bus_pkg::byte_strb_t wstrb;
		soc_bus_pkg::bus_data_t wdata;
		target = int'(rand_bits(2));
		wdata = rand_bits(32);
		if (target >= T_SLOT0) begin
			word = int'(rand_bits(2));
			wstrb = rand_bits(1) ? rand_bits(4) : 4'h0;
		end else if (rand_bits(1) && target == T_BRAM && bram_q.size() > 0) begin
			word = bram_q[rand_bits(16) % bram_q.size()];
			wstrb = 4'h0;
		end else if (target == T_SPRAM && spram_q.size() > 0 && rand_bits(1)) begin
			word = spram_q[rand_bits(16) % spram_q.size()];
			wstrb = 4'h0;
		end else begin
			word = (target == T_BRAM) ? int'(rand_bits(`SOC_BRAM_AW)) : spram_word();
			// Partial writes only land on words that hold known data
			wstrb = known_word(target, word) ? rand_bits(4) : 4'hf;
			if (wstrb == 4'h0)
				wstrb = 4'hf;
		end
		run_op(target, word, wdata, wstrb);
	endtask

	// Checker
	// --------------------
	always @(posedge clk) begin : compare
		soc_bus_pkg::bus_data_t exp_word;
		soc_bus_pkg::bus_data_t act_word;
		soc_bus_pkg::cpu_addr_t addr;
		while (act_q.size() > 0) begin
			exp_word = exp_q.pop_front();
			act_word = act_q.pop_front();
			addr = addr_q.pop_front();
			assert (act_word === exp_word) else
				stop_failed($sformatf("ERROR %0t: addr %08h expected %08h got %08h",
					$time, addr, exp_word, act_word));
		end
	end

	// Test sequence
	// --------------------
	initial begin : stimulus
		int i;
		int t;
		int w;
		soc_bus_pkg::bus_data_t d;
		soc_bus_pkg::byte_strb_t s;
		cpu_req = '0;
		wb_cyc_rst = 1'b1;
		repeat (N_RESET) @(negedge clk);
		wb_cyc_rst = 1'b0;

		// Reset state, registers read back as zero
		repeat (3) begin
			@(negedge clk);
			assert (cpu_rsp.ready === 1'b0) else
				stop_failed($sformatf("ERROR %0t: ready high after reset", $time));
		end
		for (t = T_SLOT0; t <= T_SLOT1; t++) begin
			for (w = 0; w < 4; w++)
				run_op(t, w, '0, 4'h0);
		end

		// Full word write and read back
		for (i = 0; i < N_FULL; i++) begin
			w = int'(rand_bits(`SOC_BRAM_AW));
			d = rand_bits(32);
			run_op(T_BRAM, w, d, 4'hf);
			run_op(T_BRAM, w, '0, 4'h0);
			w = spram_word();
			d = rand_bits(32);
			run_op(T_SPRAM, w, d, 4'hf);
			run_op(T_SPRAM, w, '0, 4'h0);
		end

		// Partial strobes on every target
		for (i = 0; i < N_STRB; i++) begin
			for (t = T_BRAM; t <= T_SLOT1; t++) begin
				if (t == T_BRAM)
					w = bram_q[rand_bits(16) % bram_q.size()];
				else if (t == T_SPRAM)
					w = spram_q[rand_bits(16) % spram_q.size()];
				else
					w = int'(rand_bits(2));
				s = rand_bits(4);
				if (s == 4'h0 || s == 4'hf)
					s = s ^ 4'h6;
				d = rand_bits(32);
				run_op(t, w, d, s);
				run_op(t, w, '0, 4'h0);
			end
		end

		// Same word index in BRAM and SPRAM
		for (i = 0; i < N_ALIAS; i++) begin
			w = int'(rand_bits(`SOC_BRAM_AW));
			d = rand_bits(32);
			run_op(T_BRAM, w, d, 4'hf);
			run_op(T_SPRAM, w, ~d, 4'hf);
			run_op(T_BRAM, w, '0, 4'h0);
			run_op(T_SPRAM, w, '0, 4'h0);
		end

		for (i = 0; i < N_RAND; i++)
			random_op();

		@(posedge clk);
		@(negedge clk);
		if (act_q.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stop_failed("Read results were left unchecked at the end of the run");
		end
	end

endmodule

// ==== verilog.f ====
+incdir+.
soc_bus_pkg.sv
soc_word_ram.sv
soc_wb_regs.sv
soc_cpu_bridge.sv
soc_bus_top.sv
tb_soc_bus.sv
